/* common/pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

    typedef enum logic [3:0] {
        NOP     = 4'd0,
        ADDI    = 4'd1,
        ADD     = 4'd2,
        MUL     = 4'd3,
        STORE   = 4'd4,
        SYSCALL = 4'd5,
        ERET    = 4'd6
    } op_t;

    typedef enum logic [2:0] {
        EXC_NONE     = 3'd0,
        EXC_SYSCALL  = 3'd1,
        EXC_OVERFLOW = 3'd2,
        EXC_INVALID  = 3'd3,
        EXC_ERET     = 3'd4
    } exc_t;

    // instruction word fields
    localparam int OP_MSB  = 31;
    localparam int OP_LSB  = 28;
    localparam int RD_MSB  = 27;
    localparam int RD_LSB  = 25;
    localparam int RS_MSB  = 24;
    localparam int RS_LSB  = 22;
    localparam int RT_MSB  = 21;
    localparam int RT_LSB  = 19;
    localparam int IMM_MSB = 15;
    localparam int IMM_LSB = 0;

    typedef struct packed {
        logic pc;
        logic dec;
        logic exe;
        logic res;
    } stall_t;

    typedef struct packed {
        logic        valid;
        op_t         op;
        logic [2:0]  rd;
        logic        wen;
        logic [31:0] rs_val;
        logic [31:0] rt_val;
        logic [31:0] imm;
        logic [31:0] pc;
    } dec_exe_t;

    typedef struct packed {
        logic        valid;
        op_t         op;
        logic [2:0]  rd;
        logic        wen;
        logic [31:0] result;
        logic [31:0] st_addr;
        logic [31:0] st_data;
        logic [31:0] pc;
        logic        ovf;
    } exe_res_t;

    typedef struct packed {
        logic        wen;
        logic [2:0]  rd;
        logic [31:0] data;
    } wb_t;

endpackage

`default_nettype wire

/* logic/pipe_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_fetch #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire pipe_pkg::stall_t  stall_i,
    input  wire                    flush_i,
    input  wire [31:0]             new_pc_i,
    output logic [31:0]            pc_o
);

    logic [31:0] pc_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc_q <= RESET_PC;
        end else if (flush_i) begin
            pc_q <= new_pc_i;               // trap entry or eret target
        end else if (!stall_i.pc) begin
            pc_q <= pc_q + 32'd4;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

/* logic/pipe_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_decode (
    input  wire                     clk,
    input  wire                     rst_n_i,
    input  wire [31:0]              inst_i,
    input  wire [31:0]              pc_i,
    input  wire pipe_pkg::stall_t   stall_i,
    input  wire                     flush_i,
    input  wire pipe_pkg::wb_t      wb_i,
    input  wire [2:0]               exe_rd_i,
    input  wire                     exe_wen_i,
    input  wire [2:0]               res_rd_i,
    input  wire                     res_wen_i,
    output logic                    stall_req_o,
    output pipe_pkg::dec_exe_t      dec_o
);

    logic [31:0]        rf_q [8];
    pipe_pkg::op_t      op;
    logic [2:0]         rd;
    logic [2:0]         rs;
    logic [2:0]         rt;
    logic               uses_rs;
    logic               uses_rt;
    logic               rs_busy;
    logic               rt_busy;
    pipe_pkg::dec_exe_t dec_d;

    // r0 reads as zero, same-cycle write wins over the array
    function automatic logic [31:0] read_reg(input logic [2:0] addr,
                                             input logic [31:0] stored,
                                             input pipe_pkg::wb_t wb);
        logic [31:0] val;
        if (addr == 3'd0) begin
            val = 32'd0;
        end else if (wb.wen && wb.rd == addr) begin
            val = wb.data;
        end else begin
            val = stored;
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (wb_i.wen && wb_i.rd != 3'd0) begin
            rf_q[wb_i.rd] <= wb_i.data;
        end
    end

    assign op = pipe_pkg::op_t'(inst_i[pipe_pkg::OP_MSB:pipe_pkg::OP_LSB]);
    assign rd = inst_i[pipe_pkg::RD_MSB:pipe_pkg::RD_LSB];
    assign rs = inst_i[pipe_pkg::RS_MSB:pipe_pkg::RS_LSB];
    assign rt = inst_i[pipe_pkg::RT_MSB:pipe_pkg::RT_LSB];

    assign uses_rs = op inside {pipe_pkg::ADDI, pipe_pkg::ADD, pipe_pkg::MUL, pipe_pkg::STORE};
    assign uses_rt = op inside {pipe_pkg::ADD, pipe_pkg::MUL, pipe_pkg::STORE};

    // scoreboard against execute and result
    assign rs_busy = uses_rs && rs != 3'd0 &&
                     ((exe_wen_i && exe_rd_i == rs) || (res_wen_i && res_rd_i == rs));
    assign rt_busy = uses_rt && rt != 3'd0 &&
                     ((exe_wen_i && exe_rd_i == rt) || (res_wen_i && res_rd_i == rt));

    assign stall_req_o = rs_busy || rt_busy;

    always_comb begin
        dec_d        = '0;
        dec_d.valid  = 1'b1;
        dec_d.op     = op;
        dec_d.rd     = rd;
        dec_d.wen    = (op inside {pipe_pkg::ADDI, pipe_pkg::ADD, pipe_pkg::MUL}) &&
                       rd != 3'd0;
        dec_d.rs_val = read_reg(rs, rf_q[rs], wb_i);
        dec_d.rt_val = read_reg(rt, rf_q[rt], wb_i);
        dec_d.imm    = {{16{inst_i[pipe_pkg::IMM_MSB]}},
                        inst_i[pipe_pkg::IMM_MSB:pipe_pkg::IMM_LSB]};
        dec_d.pc     = pc_i;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            dec_o.valid <= 1'b0;
        end else if (!stall_i.dec) begin
            dec_o <= dec_d;
        end else if (!stall_i.exe) begin
            dec_o.valid <= 1'b0;            // bubble while the hazard waits
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_execute #(
    parameter int MUL_CYCLES = 4
) (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire pipe_pkg::dec_exe_t   dec_i,
    input  wire pipe_pkg::stall_t     stall_i,
    input  wire                       flush_i,
    output logic                      stall_req_o,
    output pipe_pkg::exe_res_t        res_o
);

    localparam int CNT_W = $clog2(MUL_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MUL_CYCLES - 1);

    logic [CNT_W-1:0]   mul_cnt_q;
    logic               is_mul;
    logic [31:0]        op_b;
    logic [31:0]        sum;
    logic [31:0]        product;
    logic               ovf;
    pipe_pkg::exe_res_t res_d;

    assign is_mul      = dec_i.valid && dec_i.op == pipe_pkg::MUL;
    assign stall_req_o = is_mul && mul_cnt_q != CNT_LAST;

    // cycles the current multiply has spent in execute
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || !stall_i.exe) begin
            mul_cnt_q <= '0;
        end else if (stall_req_o) begin
            mul_cnt_q <= mul_cnt_q + CNT_W'(1);
        end
    end

    // one adder for addi, add and the store address
    assign op_b    = (dec_i.op == pipe_pkg::ADD) ? dec_i.rt_val : dec_i.imm;
    assign sum     = dec_i.rs_val + op_b;
    assign ovf     = (dec_i.rs_val[31] == op_b[31]) && (sum[31] != dec_i.rs_val[31]);
    assign product = dec_i.rs_val * dec_i.rt_val;   // low word only

    always_comb begin
        res_d         = '0;
        res_d.valid   = dec_i.valid;
        res_d.op      = dec_i.op;
        res_d.rd      = dec_i.rd;
        res_d.wen     = dec_i.wen;
        res_d.result  = is_mul ? product : sum;
        res_d.st_addr = sum;
        res_d.st_data = dec_i.rt_val;
        res_d.pc      = dec_i.pc;
        res_d.ovf     = ovf;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            res_o.valid <= 1'b0;
        end else if (!stall_i.exe) begin
            res_o <= res_d;
        end else if (!stall_i.res) begin
            res_o.valid <= 1'b0;            // bubble behind a held multiply
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_result.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_result (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire pipe_pkg::exe_res_t   res_i,
    input  wire                       flush_i,
    input  wire                       store_commit_i,
    output pipe_pkg::wb_t             wb_o,
    output pipe_pkg::exc_t            exc_o,
    output logic [31:0]               epc_o,
    output logic                      store_pending_o,
    output logic                      wb_valid_o,
    output logic [2:0]                wb_rd_o,
    output logic [31:0]               wb_data_o,
    output logic                      st_valid_o,
    output logic [31:0]               st_addr_o,
    output logic [31:0]               st_data_o,
    output logic                      exc_valid_o,
    output pipe_pkg::exc_t            exc_code_o
);

    logic [31:0] epc_q;

    always_comb begin
        exc_o = pipe_pkg::EXC_NONE;
        if (res_i.valid) begin
            case (res_i.op)
                pipe_pkg::NOP, pipe_pkg::MUL, pipe_pkg::STORE: begin
                    exc_o = pipe_pkg::EXC_NONE;
                end
                pipe_pkg::ADDI, pipe_pkg::ADD: begin
                    exc_o = res_i.ovf ? pipe_pkg::EXC_OVERFLOW : pipe_pkg::EXC_NONE;
                end
                pipe_pkg::SYSCALL: exc_o = pipe_pkg::EXC_SYSCALL;
                pipe_pkg::ERET:    exc_o = pipe_pkg::EXC_ERET;
                default:           exc_o = pipe_pkg::EXC_INVALID;
            endcase
        end
    end

    // return address is the instruction after the faulting one
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            epc_q <= 32'd0;
        end else if (flush_i && exc_o != pipe_pkg::EXC_ERET) begin
            epc_q <= res_i.pc + 32'd4;
        end
    end

    assign epc_o           = epc_q;
    assign store_pending_o = res_i.valid && res_i.op == pipe_pkg::STORE;

    assign wb_o.wen  = res_i.valid && res_i.wen && exc_o == pipe_pkg::EXC_NONE;
    assign wb_o.rd   = res_i.rd;
    assign wb_o.data = res_i.result;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_valid_o  <= 1'b0;
            st_valid_o  <= 1'b0;
            exc_valid_o <= 1'b0;
        end else begin
            wb_valid_o  <= wb_o.wen;
            st_valid_o  <= store_commit_i;
            exc_valid_o <= exc_o != pipe_pkg::EXC_NONE;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd_o    <= wb_o.rd;
        wb_data_o  <= wb_o.data;
        st_addr_o  <= res_i.st_addr;
        st_data_o  <= res_i.st_data;
        exc_code_o <= exc_o;
    end

endmodule

`default_nettype wire

/* logic/pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl #(
    parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100
) (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    stall_dec_i,
    input  wire                    stall_exe_i,
    input  wire                    store_pending_i,
    input  wire pipe_pkg::exc_t    exc_i,
    input  wire [31:0]             epc_i,
    output pipe_pkg::stall_t       stall_o,
    output logic                   flush_o,
    output logic [31:0]            new_pc_o,
    output logic                   store_commit_o
);

    logic store_phase_q;

    assign flush_o  = exc_i != pipe_pkg::EXC_NONE;
    assign new_pc_o = (exc_i == pipe_pkg::EXC_ERET) ? epc_i : TRAP_VECTOR;

    // second half of the store pause when set
    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_o) begin
            store_phase_q <= 1'b0;
        end else if (store_pending_i) begin
            store_phase_q <= ~store_phase_q;
        end
    end

    // a store sitting in result is served before the stage requests,
    // otherwise their bubble would push it out uncommitted
    always_comb begin
        stall_o        = '0;
        store_commit_o = 1'b0;
        if (flush_o) begin
            stall_o = '0;
        end else if (store_pending_i && !store_phase_q) begin
            stall_o.pc  = 1'b1;
            stall_o.dec = 1'b1;
            stall_o.exe = 1'b1;
            stall_o.res = 1'b1;
        end else if (store_pending_i) begin
            stall_o.pc     = 1'b1;
            stall_o.dec    = 1'b1;
            stall_o.exe    = 1'b1;
            store_commit_o = 1'b1;
        end else if (stall_exe_i) begin
            stall_o.pc  = 1'b1;
            stall_o.dec = 1'b1;
            stall_o.exe = 1'b1;
        end else if (stall_dec_i) begin
            stall_o.pc  = 1'b1;
            stall_o.dec = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* logic/pipe_top.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_top #(
    parameter logic [31:0] RESET_PC    = 32'h0000_0000,
    parameter logic [31:0] TRAP_VECTOR = 32'h0000_0100,
    parameter int          MUL_CYCLES  = 4
) (
    input  wire             clk,
    input  wire             rst_n_i,
    output logic [31:0]     pc_o,
    input  wire [31:0]      inst_i,
    output logic            wb_valid_o,
    output logic [2:0]      wb_rd_o,
    output logic [31:0]     wb_data_o,
    output logic            st_valid_o,
    output logic [31:0]     st_addr_o,
    output logic [31:0]     st_data_o,
    output logic            exc_valid_o,
    output pipe_pkg::exc_t  exc_code_o
);

    pipe_pkg::stall_t   stall;
    logic               flush;
    logic [31:0]        new_pc;
    logic               stall_dec;
    logic               stall_exe;
    logic               store_pending;
    logic               store_commit;
    pipe_pkg::exc_t     exc;
    logic [31:0]        epc;
    pipe_pkg::dec_exe_t dec;
    pipe_pkg::exe_res_t res;
    pipe_pkg::wb_t      wb;

    pipe_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall),
        .flush_i  (flush),
        .new_pc_i (new_pc),
        .pc_o     (pc_o)
    );

    pipe_decode u_decode (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .inst_i      (inst_i),
        .pc_i        (pc_o),
        .stall_i     (stall),
        .flush_i     (flush),
        .wb_i        (wb),
        .exe_rd_i    (dec.rd),
        .exe_wen_i   (dec.valid & dec.wen),
        .res_rd_i    (res.rd),
        .res_wen_i   (res.valid & res.wen),
        .stall_req_o (stall_dec),
        .dec_o       (dec)
    );

    pipe_execute #(
        .MUL_CYCLES (MUL_CYCLES)
    ) u_execute (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .dec_i       (dec),
        .stall_i     (stall),
        .flush_i     (flush),
        .stall_req_o (stall_exe),
        .res_o       (res)
    );

    pipe_result u_result (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .res_i           (res),
        .flush_i         (flush),
        .store_commit_i  (store_commit),
        .wb_o            (wb),
        .exc_o           (exc),
        .epc_o           (epc),
        .store_pending_o (store_pending),
        .wb_valid_o      (wb_valid_o),
        .wb_rd_o         (wb_rd_o),
        .wb_data_o       (wb_data_o),
        .st_valid_o      (st_valid_o),
        .st_addr_o       (st_addr_o),
        .st_data_o       (st_data_o),
        .exc_valid_o     (exc_valid_o),
        .exc_code_o      (exc_code_o)
    );

    pipe_ctrl #(
        .TRAP_VECTOR (TRAP_VECTOR)
    ) u_ctrl (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .stall_dec_i     (stall_dec),
        .stall_exe_i     (stall_exe),
        .store_pending_i (store_pending),
        .exc_i           (exc),
        .epc_i           (epc),
        .stall_o         (stall),
        .flush_o         (flush),
        .new_pc_o        (new_pc),
        .store_commit_o  (store_commit)
    );

endmodule

`default_nettype wire

/* dv/pipe_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module pipe_tb;

    localparam logic [31:0] RESET_PC    = 32'h0000_0000;
    localparam logic [31:0] TRAP_VECTOR = 32'h0000_0100;
    localparam int          MUL_CYCLES  = 3;
    localparam int          NUM_TESTS   = 6;
    localparam int          TEST_LEN    = 50;      // cycles per test before the multiply stretch
    localparam int          CYCLE_LIMIT = NUM_TESTS * TEST_LEN * MUL_CYCLES + 200;
    localparam int          MODEL_STEPS = 60;

    logic           clk;
    logic           rst_n_i;
    logic [31:0]    pc_o;
    logic [31:0]    inst_i;
    logic           wb_valid_o;
    logic [2:0]     wb_rd_o;
    logic [31:0]    wb_data_o;
    logic           st_valid_o;
    logic [31:0]    st_addr_o;
    logic [31:0]    st_data_o;
    logic           exc_valid_o;
    pipe_pkg::exc_t exc_code_o;

    logic [31:0]    imem [256];
    logic [31:0]    lfsr_q;
    int             cycles;
    int             checks;
    int             errors;

    // expected events in retire order
    logic [2:0]     exp_wr_rd [$];
    logic [31:0]    exp_wr_data [$];
    logic [31:0]    exp_st_addr [$];
    logic [31:0]    exp_st_data [$];
    pipe_pkg::exc_t exp_exc_code [$];
    logic [31:0]    exp_exc_pc [$];

    pipe_top #(
        .RESET_PC    (RESET_PC),
        .TRAP_VECTOR (TRAP_VECTOR),
        .MUL_CYCLES  (MUL_CYCLES)
    ) dut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .pc_o        (pc_o),
        .inst_i      (inst_i),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o),
        .st_valid_o  (st_valid_o),
        .st_addr_o   (st_addr_o),
        .st_data_o   (st_data_o),
        .exc_valid_o (exc_valid_o),
        .exc_code_o  (exc_code_o)
    );

    assign inst_i = imem[pc_o[9:2]];    // combinational instruction memory

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic logic [31:0] encode_inst(input logic [3:0] op, input logic [2:0] rd,
                                                input logic [2:0] rs, input logic [2:0] rt,
                                                input logic [15:0] imm);
        return {op, rd, rs, rt, 3'b000, imm};
    endfunction

    // nop opcode with the word index spread over the other fields
    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {4'h0, 4'h0, idx, ~idx, idx};
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // exact sum must fit in 32 signed bits
    function automatic logic add_overflows(input logic [31:0] a, input logic [31:0] b);
        longint s;
        s = longint'($signed(a)) + longint'($signed(b));
        return s != longint'($signed(s[31:0]));
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // in-order ISA model that builds the expected event lists
    task automatic run_model();
        logic [31:0] regs [8];
        logic [31:0] pc;
        logic [31:0] epc;
        logic [31:0] w;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [2:0]  rd;
        pc = RESET_PC;
        epc = '0;
        for (int i = 0; i < 8; i++) begin
            regs[i] = '0;
        end
        exp_wr_rd.delete();
        exp_wr_data.delete();
        exp_st_addr.delete();
        exp_st_data.delete();
        exp_exc_code.delete();
        exp_exc_pc.delete();
        repeat (MODEL_STEPS) begin
            w = imem[pc[9:2]];
            rd = w[27:25];
            a = regs[w[24:22]];
            b = regs[w[21:19]];
            imm = {{16{w[15]}}, w[15:0]};
            case (w[31:28])
                4'd0: pc = pc + 32'd4;
                4'd1, 4'd2: begin
                    if (w[31:28] == 4'd2) begin
                        imm = b;
                    end
                    if (add_overflows(a, imm)) begin
                        exp_exc_code.push_back(pipe_pkg::EXC_OVERFLOW);
                        exp_exc_pc.push_back(TRAP_VECTOR);
                        epc = pc + 32'd4;
                        pc = TRAP_VECTOR;
                    end else begin
                        if (rd != 3'd0) begin
                            regs[rd] = a + imm;
                            exp_wr_rd.push_back(rd);
                            exp_wr_data.push_back(a + imm);
                        end
                        pc = pc + 32'd4;
                    end
                end
                4'd3: begin
                    if (rd != 3'd0) begin
                        regs[rd] = a * b;
                        exp_wr_rd.push_back(rd);
                        exp_wr_data.push_back(a * b);
                    end
                    pc = pc + 32'd4;
                end
                4'd4: begin
                    exp_st_addr.push_back(a + imm);
                    exp_st_data.push_back(b);
                    pc = pc + 32'd4;
                end
                4'd5: begin
                    exp_exc_code.push_back(pipe_pkg::EXC_SYSCALL);
                    exp_exc_pc.push_back(TRAP_VECTOR);
                    epc = pc + 32'd4;
                    pc = TRAP_VECTOR;
                end
                4'd6: begin
                    exp_exc_code.push_back(pipe_pkg::EXC_ERET);
                    exp_exc_pc.push_back(epc);
                    pc = epc;
                end
                default: begin
                    exp_exc_code.push_back(pipe_pkg::EXC_INVALID);
                    exp_exc_pc.push_back(TRAP_VECTOR);
                    epc = pc + 32'd4;
                    pc = TRAP_VECTOR;
                end
            endcase
            regs[0] = '0;
        end
    endtask

    // compares every strobe against the head of its list
    always @(negedge clk) begin
        if (rst_n_i) begin
            if (wb_valid_o) begin
                assert (exp_wr_rd.size() > 0) else begin
                    $display("unexpected register write to r%0d at %0t", wb_rd_o, $time);
                    errors++;
                end
                if (exp_wr_rd.size() > 0) begin
                    compare_value("wb_rd_o", 32'(wb_rd_o), 32'(exp_wr_rd.pop_front()));
                    compare_value("wb_data_o", wb_data_o, exp_wr_data.pop_front());
                end
            end
            if (st_valid_o) begin
                assert (exp_st_addr.size() > 0) else begin
                    $display("unexpected store to %h at %0t", st_addr_o, $time);
                    errors++;
                end
                if (exp_st_addr.size() > 0) begin
                    compare_value("st_addr_o", st_addr_o, exp_st_addr.pop_front());
                    compare_value("st_data_o", st_data_o, exp_st_data.pop_front());
                end
            end
            if (exc_valid_o) begin
                assert (exp_exc_code.size() > 0) else begin
                    $display("unexpected exception %0d at %0t", exc_code_o, $time);
                    errors++;
                end
                if (exp_exc_code.size() > 0) begin
                    compare_value("exc_code_o", 32'(exc_code_o), 32'(exp_exc_code.pop_front()));
                    compare_value("pc_o", pc_o, exp_exc_pc.pop_front());
                end
            end
        end
    end

    task automatic begin_test();
        rst_n_i = 1'b0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(i[7:0]);
        end
        @(negedge clk);
    endtask

    task automatic release_reset();
        run_model();
        repeat (3) @(negedge clk);
        rst_n_i = 1'b1;
    endtask

    task automatic drain(input string name, input int errors_before);
        while (exp_wr_rd.size() > 0 || exp_st_addr.size() > 0 || exp_exc_code.size() > 0) begin
            @(negedge clk);
        end
        repeat (12) @(negedge clk);   // catch late extra strobes
        $display("test %s done, %0d errors", name, errors - errors_before);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        begin_test();
        compare_value("pc_o", pc_o, RESET_PC);
        release_reset();
        for (int k = 0; k < 6; k++) begin
            compare_value("pc_o", pc_o, RESET_PC + 32'(4 * k));
            compare_value("inst_i", inst_i, fill_word(RESET_PC[9:2] + 8'(k)));
            @(negedge clk);
        end
        drain("reset", e0);
    endtask

    task automatic test_alu_chain();
        int e0;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] r3;
        e0 = errors;
        begin_test();
        random_bits(16, r1);
        random_bits(16, r2);
        random_bits(16, r3);
        imem[0] = encode_inst(4'd1, 3'd1, 3'd0, 3'd0, r1[15:0]);
        imem[1] = encode_inst(4'd1, 3'd2, 3'd1, 3'd0, r2[15:0]);
        imem[2] = encode_inst(4'd2, 3'd3, 3'd1, 3'd2, 16'h0);
        imem[3] = encode_inst(4'd2, 3'd4, 3'd3, 3'd3, 16'h0);
        imem[4] = encode_inst(4'd1, 3'd0, 3'd4, 3'd0, 16'h0005);  // r0 stays zero
        imem[5] = encode_inst(4'd2, 3'd5, 3'd4, 3'd0, 16'h0);
        imem[6] = encode_inst(4'd1, 3'd1, 3'd1, 3'd0, r3[15:0]);
        imem[7] = encode_inst(4'd2, 3'd6, 3'd1, 3'd5, 16'h0);
        release_reset();
        drain("alu_chain", e0);
    endtask

    task automatic test_multiply();
        int e0;
        logic [31:0] x;
        logic [31:0] y;
        e0 = errors;
        begin_test();
        random_bits(16, x);
        random_bits(16, y);
        imem[0] = encode_inst(4'd1, 3'd1, 3'd0, 3'd0, x[15:0]);
        imem[1] = encode_inst(4'd1, 3'd2, 3'd0, 3'd0, y[15:0]);
        imem[2] = encode_inst(4'd3, 3'd3, 3'd1, 3'd2, 16'h0);
        imem[3] = encode_inst(4'd2, 3'd4, 3'd3, 3'd1, 16'h0);
        imem[4] = encode_inst(4'd3, 3'd5, 3'd2, 3'd2, 16'h0);
        imem[5] = encode_inst(4'd3, 3'd6, 3'd1, 3'd1, 16'h0);
        imem[6] = encode_inst(4'd2, 3'd7, 3'd6, 3'd2, 16'h0);
        release_reset();
        drain("multiply", e0);
    endtask

    task automatic test_store();
        int e0;
        logic [31:0] x;
        logic [31:0] y;
        e0 = errors;
        begin_test();
        random_bits(16, x);
        random_bits(16, y);
        imem[0] = encode_inst(4'd1, 3'd1, 3'd0, 3'd0, x[15:0]);
        imem[1] = encode_inst(4'd1, 3'd2, 3'd0, 3'd0, y[15:0]);
        imem[2] = encode_inst(4'd4, 3'd0, 3'd1, 3'd2, 16'h0040);
        imem[3] = encode_inst(4'd1, 3'd3, 3'd2, 3'd0, 16'h0001);
        imem[4] = encode_inst(4'd4, 3'd0, 3'd3, 3'd1, 16'hfff8);
        imem[5] = encode_inst(4'd4, 3'd0, 3'd2, 3'd3, 16'h0000);
        imem[6] = encode_inst(4'd2, 3'd4, 3'd3, 3'd1, 16'h0);
        release_reset();
        drain("store", e0);
    endtask

    task automatic test_syscall();
        int e0;
        logic [7:0] t;
        e0 = errors;
        t = TRAP_VECTOR[9:2];
        begin_test();
        imem[0] = encode_inst(4'd1, 3'd1, 3'd0, 3'd0, 16'h0123);
        imem[1] = encode_inst(4'd5, 3'd0, 3'd0, 3'd0, 16'h0);
        imem[2] = encode_inst(4'd1, 3'd2, 3'd1, 3'd0, 16'h0001);
        imem[3] = encode_inst(4'd2, 3'd3, 3'd2, 3'd1, 16'h0);
        imem[t]      = encode_inst(4'd1, 3'd4, 3'd0, 3'd0, 16'h0007);
        imem[t + 1]  = encode_inst(4'd1, 3'd5, 3'd4, 3'd0, 16'h0010);
        imem[t + 2]  = encode_inst(4'd6, 3'd0, 3'd0, 3'd0, 16'h0);
        release_reset();
        drain("syscall", e0);
    endtask

    task automatic test_faults();
        int e0;
        logic [7:0] t;
        e0 = errors;
        t = TRAP_VECTOR[9:2];
        begin_test();
        imem[0] = encode_inst(4'd1, 3'd1, 3'd0, 3'd0, 16'h0100);
        imem[1] = encode_inst(4'd3, 3'd2, 3'd1, 3'd1, 16'h0);     // 0x10000
        imem[2] = encode_inst(4'd1, 3'd5, 3'd0, 3'd0, 16'h7fff);
        imem[3] = encode_inst(4'd3, 3'd3, 3'd5, 3'd2, 16'h0);     // 0x7fff0000
        imem[4] = encode_inst(4'd1, 3'd4, 3'd3, 3'd0, 16'h7fff);
        imem[5] = encode_inst(4'd1, 3'd4, 3'd4, 3'd0, 16'h7fff);
        imem[6] = encode_inst(4'd1, 3'd6, 3'd4, 3'd0, 16'h7fff);  // overflows
        imem[7] = encode_inst(4'hf, 3'd7, 3'd0, 3'd0, 16'h0);     // unknown opcode
        imem[8] = encode_inst(4'd1, 3'd1, 3'd0, 3'd0, 16'h0005);
        imem[t]     = encode_inst(4'd1, 3'd7, 3'd0, 3'd0, 16'h0003);
        imem[t + 1] = encode_inst(4'd6, 3'd0, 3'd0, 3'd0, 16'h0);
        release_reset();
        drain("faults", e0);
    endtask

    initial begin
        rst_n_i = 1'b0;
        lfsr_q  = 32'h0f34_732e;
        cycles  = 0;
        checks  = 0;
        errors  = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i] = fill_word(i[7:0]);
        end
        test_reset();
        test_alu_chain();
        test_multiply();
        test_store();
        test_syscall();
        test_faults();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
common/pipe_pkg.sv
logic/pipe_fetch.sv
logic/pipe_decode.sv
logic/pipe_execute.sv
logic/pipe_result.sv
logic/pipe_ctrl.sv
logic/pipe_top.sv
dv/pipe_tb.sv

/* run.sh */
#!/bin/sh
# build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module pipe_tb -o pipe_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/pipe_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
